/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := processorCoreTb
FILELIST  := processorCore.f
BUILDDIR  := obj_dir
SIMBIN    := $(BUILDDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* alu.sv */
module alu (
	input  corePackage::aluOp_t   op,
	input  corePackage::aluMode_t mode,
	input  corePackage::word_t    readA,
	input  corePackage::word_t    readB,
	input  corePackage::word_t    imm,
	output corePackage::word_t    result
);
	import corePackage::*;

	word_t operand;
	word_t opResult;

	always_comb begin
		operand = (mode == ModeRegU4) ? imm : readB;
		case (op)
			OpMov: opResult = operand;
			OpAdd: opResult = readA + operand;
			OpSub: opResult = readA - operand;
			// Low half of the product only
			OpMul: opResult = readA * operand;
			OpAnd: opResult = readA & operand;
			OpOr:  opResult = readA | operand;
			OpXor: opResult = readA ^ operand;
			default: opResult = readA;
		endcase
	end

	always_comb begin
		case (mode)
			ModeRegbU8: begin
				result = imm;
			end
			ModeRegaU8Rb: begin
				// High byte from the instruction, low byte kept from RB
				result = {imm[7:0], readB[7:0]};
			end
			default: begin
				result = opResult;
			end
		endcase
	end

endmodule

/* clockGen.sv */
module clockGen (
	output logic CLK
);
	localparam int HalfPeriod = 10;

	initial begin
		CLK = 1'b0;
		forever begin
			#HalfPeriod CLK = ~CLK;
		end
	end

endmodule

/* corePackage.sv */
package corePackage;

	// Data, address and instruction words share one width
	typedef logic [15:0] word_t;
	typedef logic [3:0]  regIndex_t;

	typedef enum logic [1:0] {
		PhaseFetch,
		PhaseDecode,
		PhaseExecute,
		PhaseCommit
	} phase_t;

	typedef enum logic [1:0] {
		GroupAlu       = 2'd0,
		GroupLoadStore = 2'd1
	} group_t;

	typedef enum logic [2:0] {
		OpMov = 3'd0,
		OpAdd = 3'd1,
		OpSub = 3'd2,
		OpMul = 3'd3,
		OpAnd = 3'd4,
		OpOr  = 3'd5,
		OpXor = 3'd6
	} aluOp_t;

	typedef enum logic [2:0] {
		ModeRegReg   = 3'd0,
		ModeRegU4    = 3'd1,
		ModeRegbU8   = 3'd2,
		ModeRegaU8Rb = 3'd3
	} aluMode_t;

	localparam int RegCount = 16;

	// Immediate-building registers
	localparam regIndex_t RegA = 4'd14;
	localparam regIndex_t RegB = 4'd15;

	localparam word_t PcStep = 16'd2;

	// Instruction fields
	localparam int GroupMsb = 15;
	localparam int GroupLsb = 14;
	localparam int OpMsb    = 13;
	localparam int OpLsb    = 11;
	localparam int ModeMsb  = 10;
	localparam int ModeLsb  = 8;
	localparam int HiMsb    = 7;
	localparam int HiLsb    = 4;
	localparam int LoMsb    = 3;
	localparam int LoLsb    = 0;

	// Load/store operation bits
	localparam int LdsStoreBit = 0;
	localparam int LdsIncBit   = 1;

endpackage

/* instructionDecoder.sv */
module instructionDecoder (
	input  logic                   CLK,
	input  logic                   reset,
	input  logic                   fetch,
	input  corePackage::word_t     din,
	output corePackage::regIndex_t srcASel,
	output corePackage::regIndex_t srcBSel,
	output corePackage::regIndex_t writeSel,
	output corePackage::aluOp_t    op,
	output corePackage::aluMode_t  mode,
	output corePackage::word_t     imm,
	output logic                   isLoad,
	output logic                   isStore,
	output logic                   postInc,
	output logic                   writeEnable
);
	import corePackage::*;

	word_t      instr;
	group_t     group;
	logic [2:0] opField;
	aluMode_t   modeField;
	regIndex_t  fieldHi;
	regIndex_t  fieldLo;

	always_ff @(posedge CLK) begin
		if (reset) begin
			instr <= '0;
		end else if (fetch) begin
			instr <= din;
		end
	end

	assign group     = group_t'(instr[GroupMsb:GroupLsb]);
	assign opField   = instr[OpMsb:OpLsb];
	assign modeField = aluMode_t'(instr[ModeMsb:ModeLsb]);
	assign fieldHi   = instr[HiMsb:HiLsb];
	assign fieldLo   = instr[LoMsb:LoLsb];

	always_comb begin
		srcASel     = fieldHi;
		srcBSel     = fieldLo;
		writeSel    = fieldHi;
		op          = aluOp_t'(opField);
		mode        = modeField;
		imm         = '0;
		isLoad      = 1'b0;
		isStore     = 1'b0;
		postInc     = 1'b0;
		writeEnable = 1'b0;
		case (group)
			GroupAlu: begin
				case (modeField)
					ModeRegReg: begin
						writeEnable = 1'b1;
					end
					ModeRegU4: begin
						imm         = word_t'(fieldLo);
						writeEnable = 1'b1;
					end
					ModeRegbU8: begin
						imm         = word_t'(instr[HiMsb:LoLsb]);
						writeSel    = RegB;
						writeEnable = 1'b1;
					end
					ModeRegaU8Rb: begin
						imm         = word_t'(instr[HiMsb:LoLsb]);
						srcBSel     = RegB;
						writeSel    = RegA;
						writeEnable = 1'b1;
					end
					default: begin
						writeEnable = 1'b0;
					end
				endcase
			end
			GroupLoadStore: begin
				// Address register on port A, data register on port B
				srcASel  = fieldLo;
				srcBSel  = fieldHi;
				// ALU forms the incremented address as an ADD of the step
				op       = OpAdd;
				mode     = ModeRegU4;
				imm      = PcStep;
				isStore  = opField[LdsStoreBit];
				isLoad   = !opField[LdsStoreBit];
				postInc  = opField[LdsIncBit];
				writeSel = opField[LdsIncBit] ? fieldLo : fieldHi;
				writeEnable = !opField[LdsStoreBit] || opField[LdsIncBit];
			end
			default: begin
				writeEnable = 1'b0;
			end
		endcase
	end

endmodule

/* memoryInterface.sv */
module memoryInterface (
	input  logic               CLK,
	input  logic               fetch,
	input  logic               execute,
	input  corePackage::word_t pc,
	input  corePackage::word_t readA,
	input  corePackage::word_t readB,
	input  logic               isLoad,
	input  logic               isStore,
	input  corePackage::word_t din,
	output corePackage::word_t addr,
	output corePackage::word_t dout,
	output logic               rd,
	output logic               wr,
	output corePackage::word_t loadData
);

	logic dataAccess;

	assign dataAccess = execute && (isLoad || isStore);

	// Address register during a data access, otherwise the program counter
	assign addr = dataAccess ? readA : pc;
	assign dout = readB;

	assign rd = fetch || (execute && isLoad);
	assign wr = execute && isStore;

	always_ff @(posedge CLK) begin
		if (execute && isLoad) begin
			loadData <= din;
		end
	end

	noBusContention: assert property (
		@(posedge CLK)
		!(rd && wr)
	);

endmodule

/* phaseSequencer.sv */
module phaseSequencer (
	input  logic CLK,
	input  logic reset,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);
	import corePackage::*;

	phase_t phase;

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= PhaseFetch;
		end else begin
			case (phase)
				PhaseFetch: begin
					phase <= PhaseDecode;
				end
				PhaseDecode: begin
					phase <= PhaseExecute;
				end
				PhaseExecute: begin
					phase <= PhaseCommit;
				end
				default: begin
					phase <= PhaseFetch;
				end
			endcase
		end
	end

	assign fetch   = (phase == PhaseFetch);
	assign decode  = (phase == PhaseDecode);
	assign execute = (phase == PhaseExecute);
	assign commit  = (phase == PhaseCommit);

	// Blocks downstream rely on a single active phase
	onePhaseActive: assert property (
		@(posedge CLK) disable iff (reset)
		$onehot({fetch, decode, execute, commit})
	);

endmodule

/* processorCore.f */
corePackage.sv
phaseSequencer.sv
programCounter.sv
instructionDecoder.sv
registerFile.sv
alu.sv
memoryInterface.sv
processorCore.sv
clockGen.sv
processorCoreTb.sv

/* processorCore.sv */
module processorCore (
	input  logic               CLK,
	input  logic               reset,
	input  corePackage::word_t din,
	output corePackage::word_t addr,
	output corePackage::word_t dout,
	output logic               rd,
	output logic               wr,
	output logic               fetch,
	output logic               decode,
	output logic               execute,
	output logic               commit
);
	import corePackage::*;

	word_t     pc;
	regIndex_t srcASel;
	regIndex_t srcBSel;
	regIndex_t writeSel;
	aluOp_t    op;
	aluMode_t  mode;
	word_t     imm;
	word_t     readA;
	word_t     readB;
	word_t     result;
	word_t     loadData;
	word_t     writeData;
	logic      isLoad;
	logic      isStore;
	logic      postInc;
	logic      writeEnable;
	logic      commitWrite;

	phaseSequencer sequencer0 (
		.CLK(CLK),
		.reset(reset),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit)
	);

	programCounter counter0 (
		.CLK(CLK),
		.reset(reset),
		.commit(commit),
		.pc(pc)
	);

	instructionDecoder decoder0 (
		.CLK(CLK),
		.reset(reset),
		.fetch(fetch),
		.din(din),
		.srcASel(srcASel),
		.srcBSel(srcBSel),
		.writeSel(writeSel),
		.op(op),
		.mode(mode),
		.imm(imm),
		.isLoad(isLoad),
		.isStore(isStore),
		.postInc(postInc),
		.writeEnable(writeEnable)
	);

	// Loaded value goes to the data register, which wins when it is also the address register
	assign writeData   = (isLoad && (writeSel == srcBSel)) ? loadData : result;
	assign commitWrite = writeEnable && commit;

	registerFile registers0 (
		.CLK(CLK),
		.srcASel(srcASel),
		.srcBSel(srcBSel),
		.readA(readA),
		.readB(readB),
		.writeSel(writeSel),
		.writeData(writeData),
		.writeEnable(commitWrite)
	);

	alu alu0 (
		.op(op),
		.mode(mode),
		.readA(readA),
		.readB(readB),
		.imm(imm),
		.result(result)
	);

	memoryInterface bus0 (
		.CLK(CLK),
		.fetch(fetch),
		.execute(execute),
		.pc(pc),
		.readA(readA),
		.readB(readB),
		.isLoad(isLoad),
		.isStore(isStore),
		.din(din),
		.addr(addr),
		.dout(dout),
		.rd(rd),
		.wr(wr),
		.loadData(loadData)
	);

	// Post-increment writes the next word address back
	postIncWritesAddress: assert property (
		@(posedge CLK) disable iff (reset)
		(commit && postInc && (srcASel != srcBSel)) |->
			(commitWrite && (writeData == readA + PcStep))
	);

endmodule

/* processorCoreTb.sv */
module processorCoreTb;
	import corePackage::*;

	localparam int ProgLen = 200;
	localparam int TailLen = 16;
	localparam int TimeoutCycles = 4 * ProgLen + 50;
	localparam int DataWords = 512;
	localparam word_t DataBase = 16'h8000;
	localparam int TestPhase = 0;
	localparam int TestFetch = 1;
	localparam int TestData = 2;
	localparam int TestLoadStore = 3;
	localparam int TestPostInc = 4;

	logic CLK;
	logic reset;
	word_t din;
	word_t addr;
	word_t dout;
	logic rd;
	logic wr;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;

	word_t prog [ProgLen];
	word_t busMem [DataWords];
	word_t refMem [DataWords];
	word_t modelRegs [16];
	word_t incBase [16];
	bit pendingInc [16];
	bit loadedReg [16];
	word_t modelPc;
	word_t curInstr;
	int modelPhase;
	int executed;
	int cycleCount = 0;
	int otherFailures;
	int totalChecks;
	int totalErrors;
	int checkCount [5];
	int errorCount [5];
	string testNames [5] = '{"phase rotation", "fetch address", "data bus",
		"load then store", "post increment"};

	clockGen clock0 (.CLK(CLK));

	processorCore dut0 (.*);

	function automatic word_t encode(input logic [1:0] grp, input logic [2:0] opc,
			input logic [2:0] md, input logic [7:0] low);
		return {grp, opc, md, low};
	endfunction

	function automatic int dataIndex(input word_t a);
		return int'((a - DataBase) >> 1);
	endfunction

	function automatic word_t aluReference(input logic [2:0] opc, input word_t a, input word_t b);
		logic [31:0] product;
		product = {16'd0, a} * {16'd0, b};
		case (opc)
			OpMov: return b;
			OpAdd: return a + b;
			OpSub: return a - b;
			OpMul: return product[15:0];
			OpAnd: return a & b;
			OpOr: return a | b;
			OpXor: return a ^ b;
			default: return 16'h0000;
		endcase
	endfunction

	task automatic checkValue(input int testId, input word_t actual, input word_t expected,
			input string what);
		checkCount[testId]++;
		if (actual !== expected) begin
			errorCount[testId]++;
			$display("Error at time %0t: %s expected %h, got %h", $time, what, expected, actual);
		end
	endtask

	task automatic buildProgram();
		int n;
		int kind;
		word_t value;
		logic [3:0] dataReg;
		logic [3:0] pointerReg;
		logic [2:0] opc;
		logic [2:0] md;
		n = 0;
		// Every register gets a start value through RB, RA and a move
		for (int r = 0; r < 14; r++) begin
			value = (r == 12) ? DataBase : (r == 13) ? DataBase + 16'h0200 : word_t'($urandom());
			prog[n] = encode(GroupAlu, OpMov, ModeRegbU8, value[7:0]);
			prog[n + 1] = encode(GroupAlu, OpMov, ModeRegaU8Rb, value[15:8]);
			prog[n + 2] = encode(GroupAlu, OpMov, ModeRegReg, {4'(r), RegA});
			n += 3;
		end
		prog[n] = encode(GroupAlu, OpMov, ModeRegbU8, 8'($urandom()));
		prog[n + 1] = encode(GroupAlu, OpMov, ModeRegaU8Rb, 8'($urandom()));
		n += 2;
		while (n < ProgLen - TailLen) begin
			kind = $urandom_range(0, 9);
			opc = 3'($urandom_range(0, 6));
			md = 3'($urandom_range(0, 3));
			dataReg = 4'($urandom_range(0, 11));
			pointerReg = 4'(12 + $urandom_range(0, 1));
			if (kind < 6) begin
				// R12 and R13 stay data pointers, ALU results go to R0 to R11
				prog[n] = encode(GroupAlu, opc, md,
					(md < 3'd2) ? {dataReg, 4'($urandom())} : 8'($urandom()));
			end else if (kind < 8) begin
				opc = {1'b0, 1'($urandom_range(0, 1)), 1'b0};
				prog[n] = encode(GroupLoadStore, opc, 3'd0, {dataReg, pointerReg});
				if (!opc[1] && n + 1 < ProgLen - TailLen && $urandom_range(0, 1) == 1) begin
					n++;
					opc = {1'b0, 1'($urandom_range(0, 1)), 1'b1};
					prog[n] = encode(GroupLoadStore, opc, 3'd0, {dataReg, 4'(12 + $urandom_range(0, 1))});
				end
			end else begin
				opc = {1'b0, 1'($urandom_range(0, 1)), 1'b1};
				prog[n] = encode(GroupLoadStore, opc, 3'd0, {4'($urandom()), pointerReg});
			end
			n++;
		end
		// Dump all registers through R12 so every result reaches the bus
		for (int r = 0; r < TailLen; r++) begin
			prog[n] = encode(GroupLoadStore, 3'b011, 3'd0, {4'(r), 4'd12});
			n++;
		end
	endtask

	task automatic commitReference(input word_t instr);
		logic [2:0] opc;
		logic [2:0] md;
		logic [3:0] hi;
		logic [3:0] lo;
		logic [3:0] dest;
		word_t pointer;
		opc = instr[13:11];
		md = instr[10:8];
		hi = instr[7:4];
		lo = instr[3:0];
		pointer = modelRegs[lo];
		if (instr[15:14] == GroupAlu) begin
			dest = (md == ModeRegbU8) ? RegB : (md == ModeRegaU8Rb) ? RegA : hi;
			case (md)
				ModeRegReg: modelRegs[dest] = aluReference(opc, modelRegs[hi], modelRegs[lo]);
				ModeRegU4: modelRegs[dest] = aluReference(opc, modelRegs[hi], {12'd0, lo});
				ModeRegbU8: modelRegs[dest] = {8'd0, instr[7:0]};
				default: modelRegs[dest] = {instr[7:0], modelRegs[RegB][7:0]};
			endcase
			loadedReg[dest] = 1'b0;
		end else begin
			if (opc[0]) begin
				refMem[dataIndex(pointer)] = modelRegs[hi];
			end
			if (opc[1]) begin
				modelRegs[lo] = pointer + 16'd2;
				incBase[lo] = pointer;
				pendingInc[lo] = 1'b1;
				loadedReg[lo] = 1'b0;
			end
			// Loaded value lands unless post-increment claims the write
			if (!opc[0] && (!opc[1] || hi == lo)) begin
				modelRegs[hi] = refMem[dataIndex(pointer)];
				loadedReg[hi] = 1'b1;
			end
		end
	endtask

	task automatic checkExecute();
		logic [3:0] hi;
		logic [3:0] lo;
		hi = curInstr[7:4];
		lo = curInstr[3:0];
		if (curInstr[15:14] == GroupAlu) begin
			checkValue(TestData, word_t'({rd, wr}), 16'd0, "ALU execute strobes");
		end else begin
			checkValue(TestData, addr, modelRegs[lo], "data address");
			checkValue(TestData, word_t'({rd, wr}), curInstr[11] ? 16'd1 : 16'd2, "data strobes");
			if (curInstr[11]) begin
				checkValue(loadedReg[hi] ? TestLoadStore : TestData, dout, modelRegs[hi], "store data");
			end
			if (pendingInc[lo]) begin
				checkValue(TestPostInc, addr, incBase[lo] + 16'd2, "post-incremented address");
				pendingInc[lo] = 1'b0;
			end
		end
	endtask

	task automatic checkCycle();
		checkValue(TestPhase, word_t'({fetch, decode, execute, commit}), 16'h0008 >> modelPhase,
			"phase strobes");
		case (modelPhase)
			0: begin
				if (executed == 0) begin
					checkValue(TestPhase, addr, 16'h0000, "first fetch address");
				end
				checkValue(TestFetch, addr, modelPc, "fetch address");
				checkValue(TestFetch, word_t'({rd, wr}), 16'd2, "fetch strobes");
				curInstr = prog[int'(modelPc) >> 1];
			end
			1: checkValue(TestPhase, word_t'({rd, wr}), 16'd0, "decode strobes");
			2: checkExecute();
			default: begin
				commitReference(curInstr);
				modelPc += 16'd2;
				executed++;
			end
		endcase
		modelPhase = (modelPhase + 1) % 4;
	endtask

	task automatic driveMemory();
		din = 16'h0000;
		if (rd && int'(addr) < 2 * ProgLen) begin
			din = prog[int'(addr) >> 1];
		end else if (rd && addr >= DataBase && dataIndex(addr) < DataWords) begin
			din = busMem[dataIndex(addr)];
		end else if (rd) begin
			$display("Read at time %0t from address %h outside program and data memory", $time, addr);
			otherFailures++;
		end
		if (wr && addr >= DataBase && dataIndex(addr) < DataWords) begin
			busMem[dataIndex(addr)] = dout;
		end else if (wr) begin
			$display("Write at time %0t to address %h outside data memory", $time, addr);
			otherFailures++;
		end
	endtask

	always @(posedge CLK) begin
		if (!reset) begin
			cycleCount <= cycleCount + 1;
			if (cycleCount == TimeoutCycles) begin
				$display("Timeout: program did not finish within %0d cycles", TimeoutCycles);
				$display("=== FAIL ===");
				$finish;
			end
		end
	end

	initial begin
		void'($urandom(36));
		reset = 1'b1;
		din = 16'h0000;
		modelPc = 16'h0000;
		modelPhase = 0;
		executed = 0;
		otherFailures = 0;
		for (int i = 0; i < 16; i++) begin
			pendingInc[i] = 1'b0;
			loadedReg[i] = 1'b0;
		end
		for (int t = 0; t < 5; t++) begin
			checkCount[t] = 0;
			errorCount[t] = 0;
		end
		for (int i = 0; i < DataWords; i++) begin
			busMem[i] = word_t'($urandom());
			refMem[i] = busMem[i];
		end
		buildProgram();
		repeat (10) @(posedge CLK);
		#2;
		reset = 1'b0;
		while (executed < ProgLen) begin
			checkCycle();
			driveMemory();
			@(posedge CLK);
			#2;
		end
		totalChecks = 0;
		totalErrors = otherFailures;
		for (int t = 0; t < 5; t++) begin
			$display("Test %0d %s: %0d checks, %0d errors", t + 1, testNames[t],
				checkCount[t], errorCount[t]);
			totalChecks += checkCount[t];
			totalErrors += errorCount[t];
		end
		$display("Total: %0d instructions, %0d checks, %0d errors", executed, totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* programCounter.sv */
module programCounter (
	input  logic               CLK,
	input  logic               reset,
	input  logic               commit,
	output corePackage::word_t pc
);
	import corePackage::*;

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (commit) begin
			pc <= pc + PcStep;
		end
	end

	// Byte addressed, instructions are word aligned
	pcAligned: assert property (
		@(posedge CLK) disable iff (reset)
		pc[0] == 1'b0
	);

endmodule

/* registerFile.sv */
module registerFile (
	input  logic                   CLK,
	input  corePackage::regIndex_t srcASel,
	input  corePackage::regIndex_t srcBSel,
	output corePackage::word_t     readA,
	output corePackage::word_t     readB,
	input  corePackage::regIndex_t writeSel,
	input  corePackage::word_t     writeData,
	input  logic                   writeEnable
);
	import corePackage::*;

	word_t regs [RegCount];

	always_ff @(posedge CLK) begin
		if (writeEnable) begin
			regs[writeSel] <= writeData;
		end
	end

	// Asynchronous read ports
	assign readA = regs[srcASel];
	assign readB = regs[srcBSel];

endmodule
